// File: common/gpio_uart_pkg.sv
// Shared widths, baud timing, command opcodes, reply codes, engine states and GPIO control struct

package gpio_uart_pkg;

  // ----------------------------------------
  // Port and baud timing
  // ----------------------------------------
  localparam int unsigned GPIO_WIDTH   = 3;
  localparam int unsigned CLKS_PER_BIT = 8;   // Short bit time for simulation

  localparam int unsigned BAUD_CNT_W = $clog2(CLKS_PER_BIT);

  // Last cycle of a full bit and of a half bit
  localparam logic [BAUD_CNT_W-1:0] BIT_LAST  = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_CNT_W-1:0] HALF_LAST = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

  // ----------------------------------------
  // Host command protocol
  // ----------------------------------------
  typedef enum logic [7:0] {
    OP_SET_OE  = 8'h45,   // 'E'
    OP_SET_OUT = 8'h57,   // 'W'
    OP_READ    = 8'h52    // 'R'
  } opcode_t;

  localparam logic [7:0] REPLY_ACK = 8'h4B;   // 'K'
  localparam logic [7:0] REPLY_ERR = 8'h3F;   // '?'

  // Command engine states
  typedef enum logic [1:0] {
    ST_IDLE,    // Waiting for opcode
    ST_ARG,     // Waiting for data byte
    ST_REPLY    // Reply queued, transmitter busy
  } engine_state_t;

  // ----------------------------------------
  // Port drive state
  // ----------------------------------------
  typedef struct packed {
    logic [GPIO_WIDTH-1:0] oe;    // Per pad output enable
    logic [GPIO_WIDTH-1:0] out;   // Per pad output value
  } gpio_ctrl_t;

endpackage

// File: uart/uart_receiver.sv
// UART 8N1 receiver with line synchronizer, start-bit check and mid-bit sampling
`timescale 1ns/100ps

module uart_receiver (
  input  logic       clock,
  input  logic       rst,
  input  logic       uart_rx,
  output logic [7:0] rx_data,
  output logic       rx_valid
);

  import gpio_uart_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t              state;
  logic                   rx_meta;
  logic                   rx_sync;
  logic                   rx_prev;    // For falling edge detect
  logic [BAUD_CNT_W-1:0]  baud_cnt;
  logic [2:0]             bit_idx;
  logic [7:0]             shift_reg;
  logic                   mid_bit;

  assign mid_bit = (baud_cnt == BIT_LAST);

  // Line idles high, so the sync chain resets high too
  always_ff @(posedge clock) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= uart_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ----------------------------------------
  // Frame FSM
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) state <= RX_START;
        end
        RX_START: begin
          if (baud_cnt == HALF_LAST) begin  // Middle of start bit
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;  // High again means glitch
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (mid_bit) begin
            rx_valid <= rx_sync;   // Low stop bit drops the frame
            state    <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data path, LSB first
  always_ff @(posedge clock) begin
    if (state == RX_DATA && mid_bit) shift_reg <= {rx_sync, shift_reg[7:1]};
    if (state == RX_STOP && mid_bit && rx_sync) rx_data <= shift_reg;
  end

  a_rx_valid_pulse: assert property (@(posedge clock) disable iff (rst)
    rx_valid |=> !rx_valid);

endmodule

// File: uart/uart_transmitter.sv
// UART 8N1 transmitter with busy level
`timescale 1ns/100ps

module uart_transmitter (
  input  logic       clock,
  input  logic       rst,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx_busy,
  output logic       uart_tx
);

  import gpio_uart_pkg::*;

  logic [BAUD_CNT_W-1:0]  baud_cnt;
  logic [3:0]             bits_left;   // Bits still to send after the current one
  logic [8:0]             frame;       // Stop bit and data, start bit goes straight out

  // ----------------------------------------
  // Bit timing and control
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      tx_busy   <= 1'b0;
      uart_tx   <= 1'b1;
      baud_cnt  <= '0;
      bits_left <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy   <= 1'b1;
        uart_tx   <= 1'b0;      // Start bit
        baud_cnt  <= '0;
        bits_left <= 4'd9;
      end
    end else if (baud_cnt == BIT_LAST) begin
      baud_cnt <= '0;
      if (bits_left == 4'd0) begin
        tx_busy <= 1'b0;        // Stop bit done, line already high
      end else begin
        uart_tx   <= frame[0];
        bits_left <= bits_left - 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Shift register
  always_ff @(posedge clock) begin
    if (!tx_busy && tx_start) begin
      frame <= {1'b1, tx_data};
    end else if (tx_busy && baud_cnt == BIT_LAST) begin
      frame <= {1'b1, frame[8:1]};
    end
  end

  a_start_when_idle: assert property (@(posedge clock) disable iff (rst)
    tx_start |-> !tx_busy);

endmodule

// File: hdl/gpio_port_regs.sv
// GPIO output and enable registers with two-flop pin synchronizer
`timescale 1ns/100ps

module gpio_port_regs (
  input  logic                               clock,
  input  logic                               rst,
  input  logic                               wr_oe,
  input  logic                               wr_out,
  input  logic [gpio_uart_pkg::GPIO_WIDTH-1:0] wr_data,
  input  logic [gpio_uart_pkg::GPIO_WIDTH-1:0] pins,
  output gpio_uart_pkg::gpio_ctrl_t          gpio_ctrl,
  output logic [gpio_uart_pkg::GPIO_WIDTH-1:0] pins_sync
);

  import gpio_uart_pkg::*;

  logic [GPIO_WIDTH-1:0] pins_meta;

  // ----------------------------------------
  // Drive state
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      gpio_ctrl <= '0;   // All pads float
    end else begin
      if (wr_oe)  gpio_ctrl.oe  <= wr_data;
      if (wr_out) gpio_ctrl.out <= wr_data;
    end
  end

  // Pads may change at any time
  always_ff @(posedge clock) begin
    pins_meta <= pins;
    pins_sync <= pins_meta;
  end

  // Engine holds one opcode at a time
  a_one_write: assert property (@(posedge clock) disable iff (rst)
    !(wr_oe && wr_out));

endmodule

// File: hdl/command_engine.sv
// Host command FSM that parses opcodes, writes GPIO registers and queues reply bytes
`timescale 1ns/100ps

module command_engine (
  input  logic                                 clock,
  input  logic                                 rst,
  input  logic [7:0]                           rx_data,
  input  logic                                 rx_valid,
  input  logic [gpio_uart_pkg::GPIO_WIDTH-1:0] pins_sync,
  input  logic                                 tx_busy,
  output logic                                 wr_oe,
  output logic                                 wr_out,
  output logic [gpio_uart_pkg::GPIO_WIDTH-1:0] wr_data,
  output logic [7:0]                           tx_data,
  output logic                                 tx_start
);

  import gpio_uart_pkg::*;

  engine_state_t state;
  opcode_t       op;            // Pending write opcode
  logic          is_write_op;
  logic          reply_req;     // A reply becomes due this cycle
  logic          reply_rd;
  logic [7:0]    reply_val;
  logic          reply_read;    // Queued reply is the pin value
  logic [7:0]    reply_byte;

  assign is_write_op = (rx_data == OP_SET_OE) || (rx_data == OP_SET_OUT);

  // ----------------------------------------
  // Reply decode
  // ----------------------------------------
  always_comb begin
    reply_req = 1'b0;
    reply_rd  = 1'b0;
    reply_val = REPLY_ERR;
    if (rx_valid && state == ST_IDLE && !is_write_op) begin
      reply_req = 1'b1;
      reply_rd  = (rx_data == OP_READ);
    end else if (rx_valid && state == ST_ARG) begin
      reply_req = 1'b1;
      reply_val = REPLY_ACK;
    end
  end

  // Pins are taken while tx_start is high
  assign tx_data = reply_read ? {{(8 - GPIO_WIDTH){1'b0}}, pins_sync} : reply_byte;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= ST_IDLE;
      wr_oe    <= 1'b0;
      wr_out   <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      wr_oe    <= 1'b0;
      wr_out   <= 1'b0;
      tx_start <= 1'b0;
      case (state)
        ST_IDLE: if (rx_valid && is_write_op) state <= ST_ARG;
        ST_ARG: begin
          if (rx_valid) begin
            wr_oe  <= (op == OP_SET_OE);
            wr_out <= (op == OP_SET_OUT);
          end
        end
        ST_REPLY: begin  // Incoming bytes dropped here
          if (!tx_busy) begin
            tx_start <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
      if (reply_req) begin
        if (!tx_busy && !tx_start) begin
          tx_start <= 1'b1;
          state    <= ST_IDLE;
        end else begin
          state <= ST_REPLY;
        end
      end
    end
  end

  // Opcode, write data and reply payload
  always_ff @(posedge clock) begin
    if (rx_valid && state == ST_IDLE && is_write_op) op <= opcode_t'(rx_data);
    if (rx_valid && state == ST_ARG) wr_data <= rx_data[GPIO_WIDTH-1:0];
    if (reply_req) begin
      reply_read <= reply_rd;
      reply_byte <= reply_val;
    end
  end

endmodule

// File: hdl/gpio_uart_core.sv
// Core with UART receiver, command engine, GPIO port registers and UART transmitter
`timescale 1ns/100ps

module gpio_uart_core (
  input  logic                                 clock,
  input  logic                                 rst,
  input  logic                                 uart_rx,
  output logic                                 uart_tx,
  input  logic [gpio_uart_pkg::GPIO_WIDTH-1:0] pins,
  output gpio_uart_pkg::gpio_ctrl_t            gpio_ctrl
);

  import gpio_uart_pkg::*;

  logic [7:0]            rx_data;
  logic                  rx_valid;
  logic                  wr_oe;
  logic                  wr_out;
  logic [GPIO_WIDTH-1:0] wr_data;
  logic [GPIO_WIDTH-1:0] pins_sync;
  logic [7:0]            tx_data;
  logic                  tx_start;
  logic                  tx_busy;

  uart_receiver uart_receiver_i (
    .clock    (clock),
    .rst      (rst),
    .uart_rx  (uart_rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  command_engine command_engine_i (
    .clock     (clock),
    .rst       (rst),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .pins_sync (pins_sync),
    .tx_busy   (tx_busy),
    .wr_oe     (wr_oe),
    .wr_out    (wr_out),
    .wr_data   (wr_data),
    .tx_data   (tx_data),
    .tx_start  (tx_start)
  );

  gpio_port_regs gpio_port_regs_i (
    .clock     (clock),
    .rst       (rst),
    .wr_oe     (wr_oe),
    .wr_out    (wr_out),
    .wr_data   (wr_data),
    .pins      (pins),
    .gpio_ctrl (gpio_ctrl),
    .pins_sync (pins_sync)
  );

  uart_transmitter uart_transmitter_i (
    .clock    (clock),
    .rst      (rst),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .uart_tx  (uart_tx)
  );

endmodule

// File: hdl/gpio_uart_board.sv
// Board top with GPIO pad buffers, pin read-back mux, reset register and core
`timescale 1ns/100ps

module gpio_uart_board (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                uart_rx,
  output logic                                uart_tx,
  inout  wire [gpio_uart_pkg::GPIO_WIDTH-1:0] gpio
);

  import gpio_uart_pkg::*;

  gpio_ctrl_t            gpio_ctrl;
  logic [GPIO_WIDTH-1:0] pins;
  logic                  rst_q;

  // ----------------------------------------
  // Pad buffers
  // ----------------------------------------
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
    assign gpio[i] = gpio_ctrl.oe[i] ? gpio_ctrl.out[i] : 1'bz;
    // Driven pads read back their own output value
    assign pins[i] = gpio_ctrl.oe[i] ? gpio_ctrl.out[i] : gpio[i];
  end

  // Board reset re-timed to the core clock
  always_ff @(posedge clock) begin
    rst_q <= rst;
  end

  gpio_uart_core gpio_uart_core_i (
    .clock     (clock),
    .rst       (rst_q),
    .uart_rx   (uart_rx),
    .uart_tx   (uart_tx),
    .pins      (pins),
    .gpio_ctrl (gpio_ctrl)
  );

endmodule

// File: dv/gpio_uart_checker.sv
// Testbench checker with reply frame decoder, pad comparator and error counters
`timescale 1ns/100ps

module gpio_uart_checker (
  input  logic                                 clock,
  input  logic                                 rst,
  input  logic                                 uart_tx,
  input  wire  [gpio_uart_pkg::GPIO_WIDTH-1:0] gpio,
  input  logic [gpio_uart_pkg::GPIO_WIDTH-1:0] exp_pads,
  input  logic                                 pad_check
);

  import gpio_uart_pkg::*;

  logic [7:0]  exp_q[$];          // Expected reply bytes, oldest first
  int unsigned reply_errors = 0;
  int unsigned pad_errors   = 0;
  int unsigned frame_errors = 0;
  event        reply_done;        // One trigger per decoded frame

  // ----------------------------------------
  // Reply frame decoder
  // ----------------------------------------
  initial begin
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    wait (!rst);
    forever begin
      @(negedge clock);
      if (uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clock);   // Middle of start bit
        if (uart_tx !== 1'b0) begin
          $display("Start bit on uart_tx did not last to mid-bit at %0t", $time);
          frame_errors++;
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clock);
            rx_byte[i] = uart_tx;    // LSB first
          end
          repeat (CLKS_PER_BIT) @(negedge clock);
          if (exp_q.size() == 0) begin
            $display("Unexpected reply frame 0x%02h on uart_tx at %0t", rx_byte, $time);
            frame_errors++;
          end else begin
            exp_byte = exp_q.pop_front();
            if (uart_tx !== 1'b1) begin
              $display("Reply frame on uart_tx has a low stop bit at %0t", $time);
              frame_errors++;
            end else if (rx_byte !== exp_byte) begin
              $display("FAIL uart_tx reply byte: expected 0x%02h, got 0x%02h at %0t",
                       exp_byte, rx_byte, $time);
              reply_errors++;
            end
          end
          -> reply_done;
        end
      end else if (uart_tx !== 1'b1) begin  // Idle line sits high
        $display("FAIL uart_tx: expected 0x1, got 0x%01h at %0t", uart_tx, $time);
        frame_errors++;
      end
    end
  end

  // Pad levels, sampled away from the driving edge
  always @(negedge clock) begin
    if (pad_check && (gpio !== exp_pads)) begin
      $display("FAIL gpio: expected 0x%01h, got 0x%01h at %0t", exp_pads, gpio, $time);
      pad_errors++;
    end
  end

endmodule

// File: dv/gpio_uart_tb.sv
// Testbench top with clock, reset, host UART driver, pad drivers, reference model and watchdog
`timescale 1ns/100ps

module gpio_uart_tb;

  import gpio_uart_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RAND_CMDS  = 40;
  localparam int NUM_CMDS   = 5 + RAND_CMDS;   // Directed plus random
  localparam int FRAME_NS   = 10 * CLKS_PER_BIT * CLK_PERIOD;
  localparam int TIMEOUT_NS = NUM_CMDS * 3 * FRAME_NS * 2 + 2000;

  typedef struct packed {
    logic [7:0]            reply;
    logic [GPIO_WIDTH-1:0] oe;
    logic [GPIO_WIDTH-1:0] out;
    logic [GPIO_WIDTH-1:0] pads;
  } ref_result_t;

  logic                  clock;
  logic                  rst;
  logic                  uart_rx;
  logic                  uart_tx;
  wire  [GPIO_WIDTH-1:0] gpio;
  logic [GPIO_WIDTH-1:0] drive_en;     // Testbench pad drive enables
  logic [GPIO_WIDTH-1:0] drive_val;
  logic [GPIO_WIDTH-1:0] model_oe;
  logic [GPIO_WIDTH-1:0] model_out;
  logic [GPIO_WIDTH-1:0] exp_pads;
  logic                  pad_check;
  int unsigned           missing_replies;

  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_tb_pad
    assign gpio[i] = drive_en[i] ? drive_val[i] : 1'bz;
  end

  gpio_uart_board gpio_uart_board_i (
    .clock   (clock),
    .rst     (rst),
    .uart_rx (uart_rx),
    .uart_tx (uart_tx),
    .gpio    (gpio)
  );

  gpio_uart_checker gpio_uart_checker_i (
    .clock     (clock),
    .rst       (rst),
    .uart_tx   (uart_tx),
    .gpio      (gpio),
    .exp_pads  (exp_pads),
    .pad_check (pad_check)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic ref_result_t expected_result(input logic [7:0] op,
      input logic [7:0] data, input logic [GPIO_WIDTH-1:0] oe,
      input logic [GPIO_WIDTH-1:0] out, input logic [GPIO_WIDTH-1:0] pads_in);
    ref_result_t r;
    r.oe    = oe;
    r.out   = out;
    r.reply = REPLY_ERR;
    case (op)
      OP_SET_OE: begin
        r.oe    = data[GPIO_WIDTH-1:0];
        r.reply = REPLY_ACK;
      end
      OP_SET_OUT: begin
        r.out   = data[GPIO_WIDTH-1:0];
        r.reply = REPLY_ACK;
      end
      OP_READ: r.reply = {{(8 - GPIO_WIDTH){1'b0}}, (oe & out) | (~oe & pads_in)};
      default: r.reply = REPLY_ERR;
    endcase
    r.pads = (r.oe & r.out) | (~r.oe & pads_in);  // Enabled pads show out
    return r;
  endfunction

  // One 8N1 frame on uart_rx
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clock);
    end
  endtask

  task automatic set_pads(input logic [GPIO_WIDTH-1:0] value);
    @(posedge clock);
    drive_val <= value;
    repeat (4) @(posedge clock);   // Through the pin synchronizer
  endtask

  task automatic run_command(input logic [7:0] op, input logic [7:0] data);
    ref_result_t r;
    r = expected_result(op, data, model_oe, model_out, drive_val);
    gpio_uart_checker_i.exp_q.push_back(r.reply);
    @(posedge clock);
    drive_en <= ~(model_oe | r.oe);   // Let go of pads the DUT will drive
    send_byte(op);
    if (op == OP_SET_OE || op == OP_SET_OUT) send_byte(data);
    @(gpio_uart_checker_i.reply_done);
    model_oe  = r.oe;
    model_out = r.out;
    @(posedge clock);
    drive_en <= ~r.oe;
    exp_pads <= r.pads;
    repeat (3) @(posedge clock);
    pad_check <= 1'b1;
    @(posedge clock);
    pad_check <= 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [7:0]  op;
    int unsigned total;
    rst             = 1'b1;
    uart_rx         = 1'b1;
    drive_en        = '1;
    drive_val       = '0;
    model_oe        = '0;
    model_out       = '0;
    exp_pads        = '0;
    pad_check       = 1'b0;
    missing_replies = 0;
    void'($urandom(62));
    repeat (2) @(posedge clock);
    rst <= 1'b0;
    repeat (10) @(posedge clock);

    set_pads(3'b101);
    run_command(OP_READ, 8'h00);      // All pads float after reset
    run_command(OP_SET_OE, 8'h03);
    run_command(OP_SET_OUT, 8'h06);
    set_pads(3'b001);                 // Unlike out on the enabled bits
    run_command(OP_READ, 8'h00);      // Mixed directions
    run_command(8'h5A, 8'h01);        // Unknown opcode

    for (int n = 0; n < RAND_CMDS; n++) begin
      case ($urandom_range(3))
        0:       op = OP_SET_OE;
        1:       op = OP_SET_OUT;
        2:       op = OP_READ;
        default: op = 8'h30 + 8'($urandom_range(9));   // Digits, never an opcode
      endcase
      set_pads(GPIO_WIDTH'($urandom));
      run_command(op, 8'($urandom));
    end

    repeat (4 * CLKS_PER_BIT) @(posedge clock);
    if (gpio_uart_checker_i.exp_q.size() != 0) begin
      missing_replies = gpio_uart_checker_i.exp_q.size();
      $display("%0d expected reply bytes never arrived on uart_tx", missing_replies);
    end
    total = gpio_uart_checker_i.reply_errors + gpio_uart_checker_i.pad_errors
          + gpio_uart_checker_i.frame_errors + missing_replies;
    $display("Errors: reply %0d, pad %0d, frame %0d, missing %0d",
             gpio_uart_checker_i.reply_errors, gpio_uart_checker_i.pad_errors,
             gpio_uart_checker_i.frame_errors, missing_replies);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from three frames per command, doubled
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors: reply %0d, pad %0d, frame %0d, missing %0d",
             gpio_uart_checker_i.reply_errors, gpio_uart_checker_i.pad_errors,
             gpio_uart_checker_i.frame_errors, gpio_uart_checker_i.exp_q.size());
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: project.f
common/gpio_uart_pkg.sv
uart/uart_receiver.sv
uart/uart_transmitter.sv
hdl/gpio_port_regs.sv
hdl/command_engine.sv
hdl/gpio_uart_core.sv
hdl/gpio_uart_board.sv
dv/gpio_uart_checker.sv
dv/gpio_uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the GPIO UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module gpio_uart_tb \
  -Mdir obj_dir -o gpio_uart_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/gpio_uart_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation PASSED$'; then
  exit 0
else
  exit 1
fi
